// File: common/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// 3R format, inst[31:15]
`define OP3R_ADDW    17'h00020
`define OP3R_SUBW    17'h00022
`define OP3R_SLT     17'h00024
`define OP3R_SLTU    17'h00025
`define OP3R_NOR     17'h00028
`define OP3R_AND     17'h00029
`define OP3R_OR      17'h0002a
`define OP3R_XOR     17'h0002b
`define OP3R_SLLW    17'h0002e
`define OP3R_SRLW    17'h0002f
`define OP3R_SRAW    17'h00030
`define OP3R_MULW    17'h00038
`define OP3R_MULHW   17'h00039
`define OP3R_MULHWU  17'h0003a
`define OP3R_DIVW    17'h00040
`define OP3R_MODW    17'h00041
`define OP3R_DIVWU   17'h00042
`define OP3R_MODWU   17'h00043
`define OP3R_BREAK   17'h00054
`define OP3R_SYSCALL 17'h00056
`define OP3R_SLLIW   17'h00081
`define OP3R_SRLIW   17'h00089
`define OP3R_SRAIW   17'h00091
`define OP3R_IDLE    17'h00c91
`define OP3R_INVTLB  17'h00c93
`define OP3R_DBAR    17'h070e4
`define OP3R_IBAR    17'h070e5

// 2RI12 format, inst[31:22]
`define OP2RI12_SLTI  10'h008
`define OP2RI12_SLTUI 10'h009
`define OP2RI12_ADDIW 10'h00a
`define OP2RI12_ANDI  10'h00d
`define OP2RI12_ORI   10'h00e
`define OP2RI12_XORI  10'h00f

`define INVTLB_OP_MAX 5'd6

`endif

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;     // also ui5 for shift-immediates
        logic [4:0]  rj;
        logic [4:0]  rd;
    } r3_fmt_s;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri12_fmt_s;

    // same fetched word, seen by each format decoder
    typedef union packed {
        r3_fmt_s   r3;
        ri12_fmt_s ri12;
    } inst_word_u;

    typedef enum logic [7:0] {
        ALU_NOP, ALU_ADDW, ALU_SUBW, ALU_AND,
        ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_SLLW, ALU_SRLW, ALU_SRAW,
        ALU_SLLIW, ALU_SRLIW, ALU_SRAIW, ALU_MULW,
        ALU_MULHW, ALU_MULHWU, ALU_DIVW, ALU_DIVWU,
        ALU_MODW, ALU_MODWU, ALU_ADDIW, ALU_SLTI,
        ALU_SLTUI, ALU_ANDI, ALU_ORI, ALU_XORI,
        ALU_BREAK, ALU_SYSCALL, ALU_IDLE, ALU_INVTLB
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP        = 3'd0,
        SEL_ARITHMETIC = 3'd1,
        SEL_LOGIC      = 3'd2,
        SEL_MUL        = 3'd3,
        SEL_DIV        = 3'd4
    } alu_sel_e;

    // ecode values as in the ESTAT encoding
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ADEF = 7'h08,
        EXC_INE  = 7'h0d,
        EXC_IPE  = 7'h0e
    } exc_cause_e;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef struct packed {
        logic [31:0]         pc;
        isa_pkg::inst_word_u inst;
        logic                fetch_exc; // instruction-side fault from fetch
    } fetch_pkt_s;

    typedef struct packed {
        logic [31:0]       pc;
        logic [31:0]       inst;
        logic              reg1_read_en;
        logic [4:0]        reg1_read_addr;
        logic              reg2_read_en;
        logic [4:0]        reg2_read_addr;
        logic              reg_write_en;
        logic [4:0]        reg_write_addr;
        isa_pkg::alu_op_e  aluop;
        isa_pkg::alu_sel_e alusel;
        logic [31:0]       imm;
        logic              is_mul;
        logic              is_div;
        logic              is_privilege;
        logic [4:0]        invtlb_op;
        logic              claim;       // word recognised by this decoder
    } dec_op_s;

    typedef struct packed {
        logic                valid;
        isa_pkg::exc_cause_e cause;
    } exc_s;

endpackage

`default_nettype wire

// File: decoder/id_3r.sv
`timescale 1ns/1ns
`default_nettype none
`include "decode_cfg.svh"

module id_3r (
    input  isa_pkg::inst_word_u inst,
    input  logic [31:0]         pc,
    output pipe_pkg::dec_op_s   op,
    output logic                invtlb_bad
);

    isa_pkg::alu_op_e aluop;
    logic             known;

    // opcode to operation
    always_comb begin
        known = 1'b1;
        case (inst.r3.opcode)
            `OP3R_ADDW:    aluop = isa_pkg::ALU_ADDW;
            `OP3R_SUBW:    aluop = isa_pkg::ALU_SUBW;
            `OP3R_SLT:     aluop = isa_pkg::ALU_SLT;
            `OP3R_SLTU:    aluop = isa_pkg::ALU_SLTU;
            `OP3R_NOR:     aluop = isa_pkg::ALU_NOR;
            `OP3R_AND:     aluop = isa_pkg::ALU_AND;
            `OP3R_OR:      aluop = isa_pkg::ALU_OR;
            `OP3R_XOR:     aluop = isa_pkg::ALU_XOR;
            `OP3R_SLLW:    aluop = isa_pkg::ALU_SLLW;
            `OP3R_SRLW:    aluop = isa_pkg::ALU_SRLW;
            `OP3R_SRAW:    aluop = isa_pkg::ALU_SRAW;
            `OP3R_MULW:    aluop = isa_pkg::ALU_MULW;
            `OP3R_MULHW:   aluop = isa_pkg::ALU_MULHW;
            `OP3R_MULHWU:  aluop = isa_pkg::ALU_MULHWU;
            `OP3R_DIVW:    aluop = isa_pkg::ALU_DIVW;
            `OP3R_MODW:    aluop = isa_pkg::ALU_MODW;
            `OP3R_DIVWU:   aluop = isa_pkg::ALU_DIVWU;
            `OP3R_MODWU:   aluop = isa_pkg::ALU_MODWU;
            `OP3R_BREAK:   aluop = isa_pkg::ALU_BREAK;
            `OP3R_SYSCALL: aluop = isa_pkg::ALU_SYSCALL;
            `OP3R_SLLIW:   aluop = isa_pkg::ALU_SLLIW;
            `OP3R_SRLIW:   aluop = isa_pkg::ALU_SRLIW;
            `OP3R_SRAIW:   aluop = isa_pkg::ALU_SRAIW;
            `OP3R_IDLE:    aluop = isa_pkg::ALU_IDLE;
            `OP3R_INVTLB:  aluop = isa_pkg::ALU_INVTLB;
            `OP3R_DBAR,
            `OP3R_IBAR:    aluop = isa_pkg::ALU_NOP; // in-order core, barriers do nothing
            default: begin
                aluop = isa_pkg::ALU_NOP;
                known = 1'b0;
            end
        endcase
    end

    // operation to class, operands and flags
    always_comb begin
        op        = '0;
        op.pc     = pc;
        op.inst   = inst;
        op.aluop  = aluop;
        op.alusel = isa_pkg::SEL_NOP;
        op.claim  = known;
        case (aluop)
            isa_pkg::ALU_ADDW, isa_pkg::ALU_SUBW, isa_pkg::ALU_SLT, isa_pkg::ALU_SLTU,
            isa_pkg::ALU_SLLW, isa_pkg::ALU_SRLW, isa_pkg::ALU_SRAW: begin
                op.alusel       = isa_pkg::SEL_ARITHMETIC;
                op.reg1_read_en = 1'b1;
                op.reg2_read_en = 1'b1;
                op.reg_write_en = 1'b1;
            end
            isa_pkg::ALU_AND, isa_pkg::ALU_OR, isa_pkg::ALU_XOR, isa_pkg::ALU_NOR: begin
                op.alusel       = isa_pkg::SEL_LOGIC;
                op.reg1_read_en = 1'b1;
                op.reg2_read_en = 1'b1;
                op.reg_write_en = 1'b1;
            end
            isa_pkg::ALU_SLLIW, isa_pkg::ALU_SRLIW, isa_pkg::ALU_SRAIW: begin
                op.alusel       = isa_pkg::SEL_ARITHMETIC;
                op.reg1_read_en = 1'b1;
                op.reg_write_en = 1'b1;
                op.imm          = {27'd0, inst.r3.rk}; // ui5
            end
            isa_pkg::ALU_MULW, isa_pkg::ALU_MULHW, isa_pkg::ALU_MULHWU: begin
                op.alusel       = isa_pkg::SEL_MUL;
                op.reg1_read_en = 1'b1;
                op.reg2_read_en = 1'b1;
                op.reg_write_en = 1'b1;
                op.is_mul       = 1'b1;
            end
            isa_pkg::ALU_DIVW, isa_pkg::ALU_DIVWU, isa_pkg::ALU_MODW, isa_pkg::ALU_MODWU: begin
                op.alusel       = isa_pkg::SEL_DIV;
                op.reg1_read_en = 1'b1;
                op.reg2_read_en = 1'b1;
                op.reg_write_en = 1'b1;
                op.is_div       = 1'b1;
            end
            isa_pkg::ALU_IDLE: begin
                op.is_privilege = 1'b1;
            end
            isa_pkg::ALU_INVTLB: begin
                op.is_privilege = 1'b1;
                op.reg1_read_en = 1'b1; // asid
                op.reg2_read_en = 1'b1; // va
                op.invtlb_op    = inst.r3.rd;
            end
            default: begin
                op.alusel = isa_pkg::SEL_NOP; // break, syscall, barriers
            end
        endcase
        op.reg1_read_addr = op.reg1_read_en ? inst.r3.rj : 5'd0;
        op.reg2_read_addr = op.reg2_read_en ? inst.r3.rk : 5'd0;
        op.reg_write_addr = op.reg_write_en ? inst.r3.rd : 5'd0;
    end

    assign invtlb_bad = (inst.r3.opcode == `OP3R_INVTLB) && (inst.r3.rd > `INVTLB_OP_MAX);

endmodule

`default_nettype wire

// File: decoder/id_2ri12.sv
`timescale 1ns/1ns
`default_nettype none
`include "decode_cfg.svh"

module id_2ri12 (
    input  isa_pkg::inst_word_u inst,
    input  logic [31:0]         pc,
    output pipe_pkg::dec_op_s   op
);

    isa_pkg::alu_op_e aluop;
    logic             known;
    logic             sext;  // signed immediate, arithmetic class

    always_comb begin
        known = 1'b1;
        sext  = 1'b0;
        case (inst.ri12.opcode)
            `OP2RI12_ADDIW: begin
                aluop = isa_pkg::ALU_ADDIW;
                sext  = 1'b1;
            end
            `OP2RI12_SLTI: begin
                aluop = isa_pkg::ALU_SLTI;
                sext  = 1'b1;
            end
            `OP2RI12_SLTUI: begin
                aluop = isa_pkg::ALU_SLTUI;
                sext  = 1'b1; // compare is unsigned, imm still sign-extended
            end
            `OP2RI12_ANDI:  aluop = isa_pkg::ALU_ANDI;
            `OP2RI12_ORI:   aluop = isa_pkg::ALU_ORI;
            `OP2RI12_XORI:  aluop = isa_pkg::ALU_XORI;
            default: begin
                aluop = isa_pkg::ALU_NOP;
                known = 1'b0;
            end
        endcase
    end

    always_comb begin
        op        = '0;
        op.pc     = pc;
        op.inst   = inst;
        op.aluop  = aluop;
        op.alusel = isa_pkg::SEL_NOP;
        op.claim  = known;
        if (known) begin
            op.reg1_read_en   = 1'b1;
            op.reg1_read_addr = inst.ri12.rj;
            op.reg_write_en   = 1'b1;
            op.reg_write_addr = inst.ri12.rd;
            if (sext) begin
                op.alusel = isa_pkg::SEL_ARITHMETIC;
                op.imm    = {{20{inst.ri12.si12[11]}}, inst.ri12.si12};
            end else begin
                op.alusel = isa_pkg::SEL_LOGIC;
                op.imm    = {20'd0, inst.ri12.si12};
            end
        end
    end

endmodule

`default_nettype wire

// File: decoder/id_select.sv
`timescale 1ns/1ns
`default_nettype none

module id_select (
    input  pipe_pkg::dec_op_s op_3r,
    input  pipe_pkg::dec_op_s op_2ri12,
    input  logic              invtlb_bad,
    input  logic              fetch_exc,
    input  logic [1:0]        plv,
    output pipe_pkg::dec_op_s op,
    output pipe_pkg::exc_s    exc
);

    pipe_pkg::dec_op_s sel;

    // formats are disjoint, at most one claims
    always_comb begin
        if (op_3r.claim) begin
            sel = op_3r;
        end else if (op_2ri12.claim) begin
            sel = op_2ri12;
        end else begin
            sel        = '0;
            sel.pc     = op_3r.pc;
            sel.inst   = op_3r.inst;
            sel.aluop  = isa_pkg::ALU_NOP;
            sel.alusel = isa_pkg::SEL_NOP;
        end
    end

    always_comb begin
        exc.valid = 1'b1;
        if (sel.pc[1:0] != 2'b00 || fetch_exc) begin
            exc.cause = isa_pkg::EXC_ADEF;
        end else if (!sel.claim || invtlb_bad) begin
            exc.cause = isa_pkg::EXC_INE;
        end else if (sel.is_privilege && plv != 2'd0) begin
            exc.cause = isa_pkg::EXC_IPE;
        end else begin
            exc.valid = 1'b0;
            exc.cause = isa_pkg::EXC_NONE;
        end
    end

    always_comb begin
        op = sel;
        if (exc.valid) begin
            op.reg_write_en = 1'b0; // faulting op must not retire a write
        end
    end

endmodule

`default_nettype wire

// File: logic/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              flush,
    input  pipe_pkg::dec_op_s in_op,
    input  pipe_pkg::exc_s    in_exc,
    output logic              out_valid,
    output pipe_pkg::dec_op_s out_op,
    output pipe_pkg::exc_s    out_exc
);

    logic take;

    assign take = in_valid && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= take; // one-cycle strobe
        end
    end

    // held between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_op  <= '0;
            out_exc <= '0;
        end else if (take) begin
            out_op  <= in_op;
            out_exc <= in_exc;
        end
    end

endmodule

`default_nettype wire

// File: logic/decode_top.sv
`timescale 1ns/1ns
`default_nettype none

module decode_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 if_valid,
    input  logic                 flush,
    input  pipe_pkg::fetch_pkt_s if_pkt,
    input  logic [1:0]           plv,
    output logic                 id_valid,
    output pipe_pkg::dec_op_s    id_op,
    output pipe_pkg::exc_s       id_exc
);

    pipe_pkg::dec_op_s op_3r;
    pipe_pkg::dec_op_s op_2ri12;
    pipe_pkg::dec_op_s dec_op;
    pipe_pkg::exc_s    dec_exc;
    logic              invtlb_bad;

    id_3r i_id_3r (
        .inst       (if_pkt.inst),
        .pc         (if_pkt.pc),
        .op         (op_3r),
        .invtlb_bad (invtlb_bad)
    );

    id_2ri12 i_id_2ri12 (
        .inst (if_pkt.inst),
        .pc   (if_pkt.pc),
        .op   (op_2ri12)
    );

    id_select i_id_select (
        .op_3r      (op_3r),
        .op_2ri12   (op_2ri12),
        .invtlb_bad (invtlb_bad),
        .fetch_exc  (if_pkt.fetch_exc),
        .plv        (plv),
        .op         (dec_op),
        .exc        (dec_exc)
    );

    id_stage i_id_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (if_valid),
        .flush     (flush),
        .in_op     (dec_op),
        .in_exc    (dec_exc),
        .out_valid (id_valid),
        .out_op    (id_op),
        .out_exc   (id_exc)
    );

endmodule

`default_nettype wire

// File: tb/tb_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "decode_cfg.svh"

module tb_decode;

    localparam int NUM_PKTS = 74;

    logic                 clk;
    logic                 rst_n;
    logic                 if_valid;
    logic                 flush;
    pipe_pkg::fetch_pkt_s if_pkt;
    logic [1:0]           plv;
    logic                 id_valid;
    pipe_pkg::dec_op_s    id_op;
    pipe_pkg::exc_s       id_exc;

    integer      seed = 32'hd296_807b;
    logic [31:0] pc_base = 32'h1c00_0000;
    logic [31:0] last_pc;

    decode_top i_decode_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_valid (if_valid),
        .flush    (flush),
        .if_pkt   (if_pkt),
        .plv      (plv),
        .id_valid (id_valid),
        .id_op    (id_op),
        .id_exc   (id_exc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_valid(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s id_valid expected %b got %b", $time, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_op(input pipe_pkg::dec_op_s exp, input pipe_pkg::dec_op_s act,
                            input string what);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s id_op expected %h got %h", $time, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_exc(input pipe_pkg::exc_s exp, input pipe_pkg::exc_s act,
                             input string what);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s id_exc expected %h got %h", $time, what, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [31:0] enc_3r(input logic [16:0] opc, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {opc, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] opc, input logic [11:0] si12,
                                             input logic [4:0] rj, input logic [4:0] rd);
        return {opc, si12, rj, rd};
    endfunction

    // f = {reg1, reg2, write, ui5 imm, mul, div, privileged}
    function automatic pipe_pkg::dec_op_s exp_3r(input logic [31:0] pc, input logic [31:0] w,
            input isa_pkg::alu_op_e aop, input isa_pkg::alu_sel_e sel, input logic [6:0] f);
        pipe_pkg::dec_op_s e;
        e = '0;
        e.pc             = pc;
        e.inst           = w;
        e.reg1_read_en   = f[6];
        e.reg1_read_addr = f[6] ? w[9:5] : 5'd0;
        e.reg2_read_en   = f[5];
        e.reg2_read_addr = f[5] ? w[14:10] : 5'd0;
        e.reg_write_en   = f[4];
        e.reg_write_addr = f[4] ? w[4:0] : 5'd0;
        e.aluop          = aop;
        e.alusel         = sel;
        e.imm            = f[3] ? {27'd0, w[14:10]} : 32'd0;
        e.is_mul         = f[2];
        e.is_div         = f[1];
        e.is_privilege   = f[0];
        e.claim          = 1'b1;
        return e;
    endfunction

    function automatic pipe_pkg::dec_op_s nop_op(input logic [31:0] pc, input logic [31:0] w);
        pipe_pkg::dec_op_s e;
        e = '0;
        e.pc     = pc;
        e.inst   = w;
        e.aluop  = isa_pkg::ALU_NOP;
        e.alusel = isa_pkg::SEL_NOP;
        return e;
    endfunction

    // drives one strobe and waits for the negedge after the capturing edge
    task automatic issue(input logic [31:0] w, input logic fexc, input logic [1:0] lvl,
                         input logic [1:0] pc_off, input logic fl);
        @(posedge clk);
        last_pc = pc_base | {30'd0, pc_off};
        pc_base = pc_base + 32'd4;
        if_valid         <= 1'b1;
        flush            <= fl;
        if_pkt.pc        <= last_pc;
        if_pkt.inst      <= w;
        if_pkt.fetch_exc <= fexc;
        plv              <= lvl;
        @(posedge clk);
        if_valid <= 1'b0;
        flush    <= 1'b0;
        @(negedge clk);
    endtask

    task automatic expect_result(input pipe_pkg::dec_op_s e, input isa_pkg::exc_cause_e cause,
                                 input string what);
        pipe_pkg::exc_s x;
        x.valid = (cause != isa_pkg::EXC_NONE);
        x.cause = cause;
        check_valid(1'b1, id_valid, what);
        check_op(e, id_op, what);
        check_exc(x, id_exc, what);
    endtask

    task automatic run_3r(input logic [16:0] opc, input isa_pkg::alu_op_e aop,
                          input isa_pkg::alu_sel_e sel, input logic [6:0] f);
        logic [31:0] r;
        logic [31:0] w;
        r = $random(seed);
        w = enc_3r(opc, r[14:10], r[9:5], r[4:0]);
        issue(w, 1'b0, 2'd0, 2'd0, 1'b0);
        expect_result(exp_3r(last_pc, w, aop, sel, f), isa_pkg::EXC_NONE, "3r op");
    endtask

    task automatic run_ri12(input logic [9:0] opc, input isa_pkg::alu_op_e aop, input logic sx);
        logic [31:0]       r;
        logic [31:0]       w;
        pipe_pkg::dec_op_s e;
        r = $random(seed);
        r[21] = 1'b1; // top bit of si12 set so the extension shows
        w = enc_ri12(opc, r[21:10], r[9:5], r[4:0]);
        issue(w, 1'b0, 2'd0, 2'd0, 1'b0);
        e = nop_op(last_pc, w);
        e.reg1_read_en   = 1'b1;
        e.reg1_read_addr = r[9:5];
        e.reg_write_en   = 1'b1;
        e.reg_write_addr = r[4:0];
        e.aluop          = aop;
        e.alusel         = sx ? isa_pkg::SEL_ARITHMETIC : isa_pkg::SEL_LOGIC;
        e.imm            = sx ? {{20{r[21]}}, r[21:10]} : {20'd0, r[21:10]};
        e.claim          = 1'b1;
        expect_result(e, isa_pkg::EXC_NONE, "2ri12 op");
    endtask

    task automatic test_3r_ops();
        run_3r(`OP3R_ADDW, isa_pkg::ALU_ADDW, isa_pkg::SEL_ARITHMETIC, 7'b1110000);
        run_3r(`OP3R_SUBW, isa_pkg::ALU_SUBW, isa_pkg::SEL_ARITHMETIC, 7'b1110000);
        run_3r(`OP3R_SLT, isa_pkg::ALU_SLT, isa_pkg::SEL_ARITHMETIC, 7'b1110000);
        run_3r(`OP3R_SLTU, isa_pkg::ALU_SLTU, isa_pkg::SEL_ARITHMETIC, 7'b1110000);
        run_3r(`OP3R_SLLW, isa_pkg::ALU_SLLW, isa_pkg::SEL_ARITHMETIC, 7'b1110000);
        run_3r(`OP3R_SRLW, isa_pkg::ALU_SRLW, isa_pkg::SEL_ARITHMETIC, 7'b1110000);
        run_3r(`OP3R_SRAW, isa_pkg::ALU_SRAW, isa_pkg::SEL_ARITHMETIC, 7'b1110000);
        run_3r(`OP3R_AND, isa_pkg::ALU_AND, isa_pkg::SEL_LOGIC, 7'b1110000);
        run_3r(`OP3R_OR, isa_pkg::ALU_OR, isa_pkg::SEL_LOGIC, 7'b1110000);
        run_3r(`OP3R_XOR, isa_pkg::ALU_XOR, isa_pkg::SEL_LOGIC, 7'b1110000);
        run_3r(`OP3R_NOR, isa_pkg::ALU_NOR, isa_pkg::SEL_LOGIC, 7'b1110000);
        run_3r(`OP3R_SLLIW, isa_pkg::ALU_SLLIW, isa_pkg::SEL_ARITHMETIC, 7'b1011000);
        run_3r(`OP3R_SRLIW, isa_pkg::ALU_SRLIW, isa_pkg::SEL_ARITHMETIC, 7'b1011000);
        run_3r(`OP3R_SRAIW, isa_pkg::ALU_SRAIW, isa_pkg::SEL_ARITHMETIC, 7'b1011000);
        run_3r(`OP3R_MULW, isa_pkg::ALU_MULW, isa_pkg::SEL_MUL, 7'b1110100);
        run_3r(`OP3R_MULHW, isa_pkg::ALU_MULHW, isa_pkg::SEL_MUL, 7'b1110100);
        run_3r(`OP3R_MULHWU, isa_pkg::ALU_MULHWU, isa_pkg::SEL_MUL, 7'b1110100);
        run_3r(`OP3R_DIVW, isa_pkg::ALU_DIVW, isa_pkg::SEL_DIV, 7'b1110010);
        run_3r(`OP3R_MODW, isa_pkg::ALU_MODW, isa_pkg::SEL_DIV, 7'b1110010);
        run_3r(`OP3R_DIVWU, isa_pkg::ALU_DIVWU, isa_pkg::SEL_DIV, 7'b1110010);
        run_3r(`OP3R_MODWU, isa_pkg::ALU_MODWU, isa_pkg::SEL_DIV, 7'b1110010);
        run_3r(`OP3R_BREAK, isa_pkg::ALU_BREAK, isa_pkg::SEL_NOP, 7'b0000000);
        run_3r(`OP3R_SYSCALL, isa_pkg::ALU_SYSCALL, isa_pkg::SEL_NOP, 7'b0000000);
        run_3r(`OP3R_IDLE, isa_pkg::ALU_IDLE, isa_pkg::SEL_NOP, 7'b0000001); // legal at plv 0
        run_3r(`OP3R_DBAR, isa_pkg::ALU_NOP, isa_pkg::SEL_NOP, 7'b0000000);
        run_3r(`OP3R_IBAR, isa_pkg::ALU_NOP, isa_pkg::SEL_NOP, 7'b0000000);
    endtask

    task automatic test_ri12_ops();
        run_ri12(`OP2RI12_ADDIW, isa_pkg::ALU_ADDIW, 1'b1);
        run_ri12(`OP2RI12_SLTI, isa_pkg::ALU_SLTI, 1'b1);
        run_ri12(`OP2RI12_SLTUI, isa_pkg::ALU_SLTUI, 1'b1);
        run_ri12(`OP2RI12_ANDI, isa_pkg::ALU_ANDI, 1'b0);
        run_ri12(`OP2RI12_ORI, isa_pkg::ALU_ORI, 1'b0);
        run_ri12(`OP2RI12_XORI, isa_pkg::ALU_XORI, 1'b0);
    endtask

    task automatic test_exceptions();
        logic [31:0]         r;
        logic [31:0]         w;
        logic [4:0]          rd;
        pipe_pkg::dec_op_s   e;
        isa_pkg::exc_cause_e cause;
        issue(32'hffff_ffff, 1'b0, 2'd0, 2'd0, 1'b0); // no format claims this
        expect_result(nop_op(last_pc, 32'hffff_ffff), isa_pkg::EXC_INE, "unknown word");
        for (int i = 0; i < 32; i++) begin
            rd = i[4:0];
            r  = $random(seed);
            w  = enc_3r(`OP3R_INVTLB, r[14:10], r[9:5], rd);
            issue(w, 1'b0, 2'd0, 2'd0, 1'b0);
            e = exp_3r(last_pc, w, isa_pkg::ALU_INVTLB, isa_pkg::SEL_NOP, 7'b1100001);
            e.invtlb_op = rd;
            if (rd <= `INVTLB_OP_MAX) begin
                cause = isa_pkg::EXC_NONE;
            end else begin
                cause = isa_pkg::EXC_INE;
            end
            expect_result(e, cause, "invtlb");
        end
        r = $random(seed);
        w = enc_3r(`OP3R_IDLE, r[14:10], r[9:5], r[4:0]);
        issue(w, 1'b0, 2'd3, 2'd0, 1'b0);
        e = exp_3r(last_pc, w, isa_pkg::ALU_IDLE, isa_pkg::SEL_NOP, 7'b0000001);
        expect_result(e, isa_pkg::EXC_IPE, "idle at plv 3");
    endtask

    // address fault wins over an illegal word
    task automatic test_adef();
        logic [31:0]       r;
        logic [31:0]       w;
        pipe_pkg::dec_op_s e;
        issue(32'hffff_ffff, 1'b0, 2'd0, 2'b10, 1'b0);
        expect_result(nop_op(last_pc, 32'hffff_ffff), isa_pkg::EXC_ADEF, "misaligned pc");
        issue(32'hffff_ffff, 1'b1, 2'd0, 2'd0, 1'b0);
        expect_result(nop_op(last_pc, 32'hffff_ffff), isa_pkg::EXC_ADEF, "fetch fault");
        r = $random(seed);
        w = enc_3r(`OP3R_ADDW, r[14:10], r[9:5], r[4:0]);
        issue(w, 1'b1, 2'd0, 2'd0, 1'b0);
        e = exp_3r(last_pc, w, isa_pkg::ALU_ADDW, isa_pkg::SEL_ARITHMETIC, 7'b1110000);
        e.reg_write_en = 1'b0; // a faulting op writes no register
        expect_result(e, isa_pkg::EXC_ADEF, "fetch fault on addw");
    endtask

    task automatic test_burst_flush();
        pipe_pkg::dec_op_s q[$];
        pipe_pkg::dec_op_s e;
        logic [31:0]       r;
        logic [31:0]       w;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            r       = $random(seed);
            w       = enc_3r(`OP3R_ADDW, r[14:10], r[9:5], r[4:0]);
            last_pc = pc_base;
            pc_base = pc_base + 32'd4;
            q.push_back(exp_3r(last_pc, w, isa_pkg::ALU_ADDW, isa_pkg::SEL_ARITHMETIC,
                               7'b1110000));
            if_valid         <= 1'b1;
            if_pkt.pc        <= last_pc;
            if_pkt.inst      <= w;
            if_pkt.fetch_exc <= 1'b0;
            plv              <= 2'd0;
            if (i > 0) begin
                @(negedge clk);
                expect_result(q.pop_front(), isa_pkg::EXC_NONE, "burst");
            end
        end
        @(posedge clk);
        if_valid <= 1'b0;
        @(negedge clk);
        e = q.pop_front();
        expect_result(e, isa_pkg::EXC_NONE, "burst last");
        @(negedge clk);
        check_valid(1'b0, id_valid, "after burst");
        issue(enc_ri12(`OP2RI12_ORI, 12'h5a5, 5'd3, 5'd4), 1'b0, 2'd0, 2'd0, 1'b1);
        check_valid(1'b0, id_valid, "flushed strobe");
        check_op(e, id_op, "held after flush");
    endtask

    initial begin
        #(NUM_PKTS * 80 + 2000);
        $display("timeout: decode run did not finish in the expected time");
        abort_run();
    end

    initial begin
        rst_n    = 1'b0;
        if_valid = 1'b0;
        flush    = 1'b0;
        if_pkt   = '0;
        plv      = 2'd0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_valid(1'b0, id_valid, "after reset");
        check_op('0, id_op, "after reset");
        check_exc('0, id_exc, "after reset");
        test_3r_ops();
        test_ri12_ops();
        test_exceptions();
        test_adef();
        test_burst_flush();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
decoder/id_3r.sv
decoder/id_2ri12.sv
decoder/id_select.sv
logic/id_stage.sv
logic/decode_top.sv
tb/tb_decode.sv
